//--- rv_core_cfg.svh
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// first fetch address after reset
`define RV_RESET_VECTOR 32'h0000_0000
`define RV_INSTR_LEN    32'd4
`define RV_NUM_REGS     32

// major opcodes
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_OP     7'b0110011
`define RV_OP_OP_IMM 7'b0010011
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111
`define RV_OP_BRANCH 7'b1100011

// funct3 for OP and OP-IMM
`define RV_F3_ADD_SUB 3'b000
`define RV_F3_SLL     3'b001
`define RV_F3_SLT     3'b010
`define RV_F3_SLTU    3'b011
`define RV_F3_XOR     3'b100
`define RV_F3_SRL_SRA 3'b101
`define RV_F3_OR      3'b110
`define RV_F3_AND     3'b111

// funct3 for branches
`define RV_F3_BEQ  3'b000
`define RV_F3_BNE  3'b001
`define RV_F3_BLT  3'b100
`define RV_F3_BGE  3'b101
`define RV_F3_BLTU 3'b110
`define RV_F3_BGEU 3'b111

`endif

//--- source/rv_pkg.sv
`default_nettype none

package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    typedef enum logic [2:0] {
        ST_RESET,
        ST_FETCH,
        ST_DECODE,
        ST_EXEC,
        ST_LOAD,
        ST_STORE,
        ST_BRANCH
    } ctrl_state_t;

    // fields of the instruction held by the decoder
    typedef struct packed {
        logic [6:0] opcode;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        logic [2:0] funct3;
        // instr[30], selects SUB and SRA
        logic       alt;
        word_t      imm;
    } decoded_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  we;
        logic  cyc;
        logic  stb;
    } bus_req_t;

    typedef struct packed {
        word_t rdata;
        logic  ack;
    } bus_rsp_t;

    typedef struct packed {
        logic eq;
        logic lt;
        logic ltu;
    } alu_flags_t;

endpackage

`default_nettype wire

//--- source/rv_alu.sv
`default_nettype none

module rv_alu (
    input  logic               clk,
    input  logic               alu_en,
    input  rv_pkg::alu_op_t    alu_op,
    input  rv_pkg::word_t      a,
    input  rv_pkg::word_t      b,
    output rv_pkg::word_t      result,
    output rv_pkg::alu_flags_t flags
);

    rv_pkg::word_t res_d;
    logic [4:0]    shamt;
    logic          lt;
    logic          ltu;

    assign shamt = b[4:0];
    assign lt    = $signed(a) < $signed(b);
    assign ltu   = a < b;

    always_comb begin
        case (alu_op)
            rv_pkg::ALU_ADD:  res_d = a + b;
            rv_pkg::ALU_SUB:  res_d = a - b;
            rv_pkg::ALU_SLL:  res_d = a << shamt;
            rv_pkg::ALU_SLT:  res_d = {31'b0, lt};
            rv_pkg::ALU_SLTU: res_d = {31'b0, ltu};
            rv_pkg::ALU_XOR:  res_d = a ^ b;
            rv_pkg::ALU_SRL:  res_d = a >> shamt;
            rv_pkg::ALU_SRA:  res_d = $signed(a) >>> shamt;
            rv_pkg::ALU_OR:   res_d = a | b;
            rv_pkg::ALU_AND:  res_d = a & b;
            default:          res_d = a + b;
        endcase
    end

    // result and flags hold until the next enable
    always_ff @(posedge clk) begin
        if (alu_en) begin
            result    <= res_d;
            flags.eq  <= (a == b);
            flags.lt  <= lt;
            flags.ltu <= ltu;
        end
    end

endmodule

`default_nettype wire

//--- source/rv_regfile.sv
`default_nettype none

`include "rv_core_cfg.svh"

module rv_regfile (
    input  logic             clk,
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rs2,
    output rv_pkg::word_t    rs1_val,
    output rv_pkg::word_t    rs2_val,
    input  rv_pkg::reg_idx_t rd,
    input  logic             we,
    input  rv_pkg::word_t    wdata
);

    // x0 has no storage
    rv_pkg::word_t regs [1:`RV_NUM_REGS-1];

    always_ff @(posedge clk) begin
        if (we && (rd != '0)) begin
            regs[rd] <= wdata;
        end
    end

    assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- source/rv_decoder.sv
`default_nettype none

`include "rv_core_cfg.svh"

module rv_decoder (
    input  logic             clk,
    input  logic             dec_en,
    input  rv_pkg::word_t    instr,
    output rv_pkg::decoded_t dec
);

    rv_pkg::word_t instr_q;
    rv_pkg::word_t imm_i;
    rv_pkg::word_t imm_s;
    rv_pkg::word_t imm_b;
    rv_pkg::word_t imm_u;
    rv_pkg::word_t imm_j;

    always_ff @(posedge clk) begin
        if (dec_en) begin
            instr_q <= instr;
        end
    end

    // immediate formats, all sign-extended from bit 31
    assign imm_i = {{20{instr_q[31]}}, instr_q[31:20]};
    assign imm_s = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
    assign imm_b = {{19{instr_q[31]}}, instr_q[31], instr_q[7], instr_q[30:25],
                    instr_q[11:8], 1'b0};
    assign imm_u = {instr_q[31:12], 12'b0};
    assign imm_j = {{11{instr_q[31]}}, instr_q[31], instr_q[19:12], instr_q[20],
                    instr_q[30:21], 1'b0};

    always_comb begin
        dec.opcode = instr_q[6:0];
        dec.rd     = instr_q[11:7];
        dec.funct3 = instr_q[14:12];
        dec.rs1    = instr_q[19:15];
        dec.rs2    = instr_q[24:20];
        dec.alt    = instr_q[30];
        case (instr_q[6:0])
            `RV_OP_STORE:             dec.imm = imm_s;
            `RV_OP_BRANCH:            dec.imm = imm_b;
            `RV_OP_LUI, `RV_OP_AUIPC: dec.imm = imm_u;
            `RV_OP_JAL:               dec.imm = imm_j;
            // OP-IMM, LOAD, JALR and the rest
            default:                  dec.imm = imm_i;
        endcase
    end

endmodule

`default_nettype wire

//--- source/rv_bus_master.sv
`default_nettype none

module rv_bus_master (
    input  logic             clk,
    input  logic             reset,
    input  logic             start,
    input  logic             from_pc,
    input  rv_pkg::word_t    pc,
    input  rv_pkg::word_t    alu_addr,
    input  logic             we,
    input  rv_pkg::word_t    wdata,
    output logic             busy,
    output rv_pkg::word_t    rdata,
    output rv_pkg::bus_req_t bus_req,
    input  rv_pkg::bus_rsp_t bus_rsp
);

    rv_pkg::word_t addr_q;
    rv_pkg::word_t wdata_q;
    rv_pkg::word_t rdata_q;
    logic          cyc_q;
    logic          we_q;
    logic          done;

    assign done = cyc_q && bus_rsp.ack;

    // cyc and stb rise and fall together
    always_ff @(posedge clk) begin
        if (reset) begin
            cyc_q <= 1'b0;
            we_q  <= 1'b0;
        end else if (start) begin
            cyc_q <= 1'b1;
            we_q  <= we;
        end else if (done) begin
            cyc_q <= 1'b0;
            we_q  <= 1'b0;
        end
    end

    // address and data stay stable for the whole cycle
    always_ff @(posedge clk) begin
        if (start) begin
            addr_q  <= from_pc ? pc : alu_addr;
            wdata_q <= wdata;
        end
        if (done) begin
            rdata_q <= bus_rsp.rdata;
        end
    end

    assign busy    = cyc_q;
    assign rdata   = rdata_q;
    assign bus_req = '{addr: addr_q, wdata: wdata_q, we: we_q, cyc: cyc_q, stb: cyc_q};

endmodule

`default_nettype wire

//--- source/rv_control.sv
`default_nettype none

`include "rv_core_cfg.svh"

module rv_control (
    input  logic               clk,
    input  logic               reset,
    input  rv_pkg::decoded_t   dec,
    output logic               dec_en,
    input  rv_pkg::word_t      rs1_val,
    input  rv_pkg::word_t      rs2_val,
    output logic               alu_en,
    output rv_pkg::alu_op_t    alu_op,
    output rv_pkg::word_t      alu_a,
    output rv_pkg::word_t      alu_b,
    input  rv_pkg::word_t      alu_result,
    input  rv_pkg::alu_flags_t alu_flags,
    output logic               rd_we,
    output rv_pkg::word_t      rd_data,
    output logic               bus_start,
    output logic               bus_from_pc,
    output logic               bus_we,
    input  logic               bus_busy,
    input  rv_pkg::word_t      bus_rdata,
    output rv_pkg::word_t      pc
);

    rv_pkg::ctrl_state_t state_q;
    rv_pkg::word_t       pc_q;
    rv_pkg::word_t       pc_next_q;
    rv_pkg::word_t       fetch_pc;
    rv_pkg::alu_op_t     exec_op;
    logic                take_alu_q;
    logic                wb_alu_q;
    logic                wb_bus_q;
    logic                wb_imm_q;
    logic                advance;
    logic                br_taken;
    logic                is_op;
    logic                is_jump;

    // hold everything while a bus cycle is open
    assign advance = !bus_busy;
    assign is_op   = (dec.opcode == `RV_OP_OP);
    assign is_jump = (dec.opcode == `RV_OP_JAL) || (dec.opcode == `RV_OP_JALR);

    // jump and taken-branch targets arrive on the ALU result
    assign fetch_pc = take_alu_q ? {alu_result[31:1], 1'b0} : pc_next_q;
    assign pc       = (state_q == rv_pkg::ST_FETCH) ? fetch_pc : pc_q;

    // funct3/funct7 to ALU operation, SUB only exists for OP
    always_comb begin
        exec_op = rv_pkg::ALU_ADD;
        case (dec.funct3)
            `RV_F3_ADD_SUB: exec_op = (is_op && dec.alt) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            `RV_F3_SLL:     exec_op = rv_pkg::ALU_SLL;
            `RV_F3_SLT:     exec_op = rv_pkg::ALU_SLT;
            `RV_F3_SLTU:    exec_op = rv_pkg::ALU_SLTU;
            `RV_F3_XOR:     exec_op = rv_pkg::ALU_XOR;
            `RV_F3_SRL_SRA: exec_op = dec.alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            `RV_F3_OR:      exec_op = rv_pkg::ALU_OR;
            `RV_F3_AND:     exec_op = rv_pkg::ALU_AND;
            default:        exec_op = rv_pkg::ALU_ADD;
        endcase
    end

    // flags come from the rs1/rs2 compare done in EXEC
    always_comb begin
        case (dec.funct3)
            `RV_F3_BEQ:  br_taken = alu_flags.eq;
            `RV_F3_BNE:  br_taken = !alu_flags.eq;
            `RV_F3_BLT:  br_taken = alu_flags.lt;
            `RV_F3_BGE:  br_taken = !alu_flags.lt;
            `RV_F3_BLTU: br_taken = alu_flags.ltu;
            `RV_F3_BGEU: br_taken = !alu_flags.ltu;
            default:     br_taken = 1'b0;
        endcase
    end

    always_comb begin
        dec_en      = 1'b0;
        alu_en      = 1'b0;
        alu_op      = rv_pkg::ALU_ADD;
        alu_a       = rs1_val;
        alu_b       = rs2_val;
        bus_start   = 1'b0;
        bus_from_pc = 1'b0;
        bus_we      = 1'b0;
        case (state_q)
            rv_pkg::ST_FETCH: begin
                bus_start   = 1'b1;
                bus_from_pc = 1'b1;
            end
            rv_pkg::ST_DECODE: begin
                // ALU is free here, compute PC+4
                dec_en = 1'b1;
                alu_en = 1'b1;
                alu_a  = pc_q;
                alu_b  = `RV_INSTR_LEN;
            end
            rv_pkg::ST_EXEC: begin
                alu_en = 1'b1;
                case (dec.opcode)
                    `RV_OP_OP: alu_op = exec_op;
                    `RV_OP_OP_IMM: begin
                        alu_op = exec_op;
                        alu_b  = dec.imm;
                    end
                    `RV_OP_LOAD, `RV_OP_STORE, `RV_OP_JALR: alu_b = dec.imm;
                    `RV_OP_JAL, `RV_OP_AUIPC: begin
                        alu_a = pc_q;
                        alu_b = dec.imm;
                    end
                    `RV_OP_BRANCH: alu_op = rv_pkg::ALU_SUB;
                    default: alu_en = 1'b0;
                endcase
            end
            rv_pkg::ST_LOAD: bus_start = 1'b1;
            rv_pkg::ST_STORE: begin
                bus_start = 1'b1;
                bus_we    = 1'b1;
            end
            rv_pkg::ST_BRANCH: begin
                // branch target, used only if taken
                alu_en = 1'b1;
                alu_a  = pc_q;
                alu_b  = dec.imm;
            end
            default: ;
        endcase
        if (bus_busy) begin
            dec_en    = 1'b0;
            alu_en    = 1'b0;
            bus_start = 1'b0;
        end
    end

    // link value is PC+4 on the ALU output during EXEC
    always_comb begin
        rd_we   = 1'b0;
        rd_data = alu_result;
        if (state_q == rv_pkg::ST_FETCH) begin
            rd_we = advance && (wb_alu_q || wb_bus_q || wb_imm_q);
            if (wb_bus_q) begin
                rd_data = bus_rdata;
            end else if (wb_imm_q) begin
                rd_data = dec.imm;
            end
        end else if (state_q == rv_pkg::ST_EXEC) begin
            rd_we = is_jump;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q    <= rv_pkg::ST_RESET;
            take_alu_q <= 1'b0;
            wb_alu_q   <= 1'b0;
            wb_bus_q   <= 1'b0;
            wb_imm_q   <= 1'b0;
        end else if (advance) begin
            case (state_q)
                rv_pkg::ST_RESET: begin
                    pc_q      <= `RV_RESET_VECTOR;
                    pc_next_q <= `RV_RESET_VECTOR;
                    state_q   <= rv_pkg::ST_FETCH;
                end
                rv_pkg::ST_FETCH: begin
                    pc_q       <= fetch_pc;
                    take_alu_q <= 1'b0;
                    wb_alu_q   <= 1'b0;
                    wb_bus_q   <= 1'b0;
                    wb_imm_q   <= 1'b0;
                    state_q    <= rv_pkg::ST_DECODE;
                end
                rv_pkg::ST_DECODE: state_q <= rv_pkg::ST_EXEC;
                rv_pkg::ST_EXEC: begin
                    pc_next_q <= alu_result;
                    state_q   <= rv_pkg::ST_FETCH;
                    case (dec.opcode)
                        `RV_OP_OP, `RV_OP_OP_IMM, `RV_OP_AUIPC: wb_alu_q <= 1'b1;
                        `RV_OP_LUI:                 wb_imm_q <= 1'b1;
                        `RV_OP_LOAD:                state_q <= rv_pkg::ST_LOAD;
                        `RV_OP_STORE:               state_q <= rv_pkg::ST_STORE;
                        `RV_OP_JAL, `RV_OP_JALR:    take_alu_q <= 1'b1;
                        `RV_OP_BRANCH:              state_q <= rv_pkg::ST_BRANCH;
                        // fence and anything unknown fall through as a no-op
                        default: ;
                    endcase
                end
                rv_pkg::ST_LOAD: begin
                    wb_bus_q <= 1'b1;
                    state_q  <= rv_pkg::ST_FETCH;
                end
                rv_pkg::ST_STORE: state_q <= rv_pkg::ST_FETCH;
                rv_pkg::ST_BRANCH: begin
                    take_alu_q <= br_taken;
                    state_q    <= rv_pkg::ST_FETCH;
                end
                default: state_q <= rv_pkg::ST_RESET;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/rv_core.sv
`default_nettype none

module rv_core (
    input  logic             clk,
    input  logic             reset,
    output rv_pkg::bus_req_t bus_req,
    input  rv_pkg::bus_rsp_t bus_rsp
);

    rv_pkg::decoded_t   dec;
    rv_pkg::alu_op_t    alu_op;
    rv_pkg::alu_flags_t alu_flags;
    rv_pkg::word_t      rs1_val;
    rv_pkg::word_t      rs2_val;
    rv_pkg::word_t      alu_a;
    rv_pkg::word_t      alu_b;
    rv_pkg::word_t      alu_result;
    rv_pkg::word_t      rd_data;
    rv_pkg::word_t      bus_rdata;
    rv_pkg::word_t      pc;
    logic               dec_en;
    logic               alu_en;
    logic               rd_we;
    logic               bus_start;
    logic               bus_from_pc;
    logic               bus_we;
    logic               bus_busy;

    rv_control u_control (
        .clk        (clk),
        .reset      (reset),
        .dec        (dec),
        .dec_en     (dec_en),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val),
        .alu_en     (alu_en),
        .alu_op     (alu_op),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_result (alu_result),
        .alu_flags  (alu_flags),
        .rd_we      (rd_we),
        .rd_data    (rd_data),
        .bus_start  (bus_start),
        .bus_from_pc(bus_from_pc),
        .bus_we     (bus_we),
        .bus_busy   (bus_busy),
        .bus_rdata  (bus_rdata),
        .pc         (pc)
    );

    // fetched word comes straight from the bus master's read latch
    rv_decoder u_decoder (
        .clk   (clk),
        .dec_en(dec_en),
        .instr (bus_rdata),
        .dec   (dec)
    );

    rv_alu u_alu (
        .clk   (clk),
        .alu_en(alu_en),
        .alu_op(alu_op),
        .a     (alu_a),
        .b     (alu_b),
        .result(alu_result),
        .flags (alu_flags)
    );

    rv_regfile u_regfile (
        .clk    (clk),
        .rs1    (dec.rs1),
        .rs2    (dec.rs2),
        .rs1_val(rs1_val),
        .rs2_val(rs2_val),
        .rd     (dec.rd),
        .we     (rd_we),
        .wdata  (rd_data)
    );

    // load/store address is the ALU result, store data is rs2
    rv_bus_master u_bus_master (
        .clk     (clk),
        .reset   (reset),
        .start   (bus_start),
        .from_pc (bus_from_pc),
        .pc      (pc),
        .alu_addr(alu_result),
        .we      (bus_we),
        .wdata   (rs2_val),
        .busy    (bus_busy),
        .rdata   (bus_rdata),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp)
    );

endmodule

`default_nettype wire

//--- testbench/tb_rv_core.sv
`default_nettype none

module tb_rv_core;

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] F7_ALT     = 7'b0100000;
    localparam int         MEM_WORDS  = 256;

    logic             clk;
    logic             reset;
    rv_pkg::bus_req_t bus_req;
    rv_pkg::bus_rsp_t bus_rsp;

    logic [31:0]   mem [0:MEM_WORDS-1];
    logic [31:0]   prog [0:63];
    rv_pkg::word_t exp_addr [0:31];
    rv_pkg::word_t exp_data [0:31];
    rv_pkg::word_t jump_from [0:2];
    rv_pkg::word_t jump_to [0:2];
    int            n_prog;
    int            n_stores;
    int            store_idx;
    int            jumps_seen;
    int            cycles;
    int            limit;
    int            wait_left;
    logic          in_cycle;
    logic          first_seen;
    logic          expect_fetch;
    rv_pkg::word_t fetch_target;
    logic [31:0]   rng_state;

    rv_core u_rv_core (
        .clk    (clk),
        .reset  (reset),
        .bus_req(bus_req),
        .bus_rsp(bus_rsp)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // instruction formats from the RV32I spec
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_sw(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    task automatic fail_now();
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input rv_pkg::word_t exp,
                              input rv_pkg::word_t act);
        if (exp !== act) begin
            $display("CHECK FAILED time=%0t %s expected=%h actual=%h", $time, name, exp, act);
            fail_now();
        end
    endtask

    task automatic check_req(input string name, input rv_pkg::bus_req_t exp,
                             input rv_pkg::bus_req_t act);
        if (exp.addr !== act.addr || exp.we !== act.we) begin
            $display("CHECK FAILED time=%0t %s expected addr=%h we=%b actual addr=%h we=%b",
                     $time, name, exp.addr, exp.we, act.addr, act.we);
            fail_now();
        end
    endtask

    task automatic add_instr(input logic [31:0] w);
        prog[n_prog] = w;
        n_prog++;
    endtask

    task automatic add_store(input rv_pkg::word_t a, input rv_pkg::word_t d);
        exp_addr[n_stores] = a;
        exp_data[n_stores] = d;
        n_stores++;
    endtask

    // marker store that a correct branch or jump skips
    task automatic add_marker();
        add_instr(enc_sw(12'h100, 5'd0, 5'd10));
    endtask

    task automatic build_program();
        add_instr(enc_i(12'd5, 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
        add_instr(enc_i(12'hffd, 5'd0, 3'b000, 5'd2, OPC_OP_IMM));
        add_instr(enc_i(12'h200, 5'd0, 3'b000, 5'd10, OPC_OP_IMM));
        add_instr(enc_sw(12'd0, 5'd1, 5'd10));
        add_instr(enc_r(7'd0, 5'd2, 5'd1, 3'b000, 5'd3));
        add_instr(enc_sw(12'd4, 5'd3, 5'd10));
        add_instr(enc_r(F7_ALT, 5'd2, 5'd1, 3'b000, 5'd4));
        add_instr(enc_sw(12'd8, 5'd4, 5'd10));
        add_instr(enc_r(7'd0, 5'd2, 5'd1, 3'b100, 5'd5));
        add_instr(enc_sw(12'd12, 5'd5, 5'd10));
        add_instr(enc_r(7'd0, 5'd2, 5'd1, 3'b110, 5'd6));
        add_instr(enc_sw(12'd16, 5'd6, 5'd10));
        add_instr(enc_r(7'd0, 5'd2, 5'd1, 3'b111, 5'd7));
        add_instr(enc_sw(12'd20, 5'd7, 5'd10));
        add_instr(enc_r(7'd0, 5'd1, 5'd1, 3'b001, 5'd8));
        add_instr(enc_sw(12'd24, 5'd8, 5'd10));
        add_instr(enc_r(F7_ALT, 5'd1, 5'd2, 3'b101, 5'd9));
        add_instr(enc_sw(12'd28, 5'd9, 5'd10));
        add_instr(enc_r(7'd0, 5'd1, 5'd2, 3'b010, 5'd12));
        add_instr(enc_sw(12'd32, 5'd12, 5'd10));
        add_instr(enc_r(7'd0, 5'd1, 5'd2, 3'b011, 5'd13));
        add_instr(enc_sw(12'd36, 5'd13, 5'd10));
        // load from the data region and add one
        add_instr(enc_i(12'h100, 5'd0, 3'b010, 5'd15, OPC_LOAD));
        add_instr(enc_i(12'd1, 5'd15, 3'b000, 5'd15, OPC_OP_IMM));
        add_instr(enc_sw(12'd40, 5'd15, 5'd10));
        add_instr(enc_i(12'd5, 5'd0, 3'b000, 5'd16, OPC_OP_IMM));
        // taken branch skips a marker and not-taken one runs a real store
        add_instr(enc_b(13'd8, 5'd16, 5'd1, 3'b000));
        add_marker();
        add_instr(enc_b(13'd8, 5'd2, 5'd1, 3'b000));
        add_instr(enc_sw(12'd44, 5'd1, 5'd10));
        add_instr(enc_b(13'd8, 5'd2, 5'd1, 3'b001));
        add_marker();
        add_instr(enc_b(13'd8, 5'd16, 5'd1, 3'b001));
        add_instr(enc_sw(12'd48, 5'd2, 5'd10));
        add_instr(enc_b(13'd8, 5'd1, 5'd2, 3'b100));
        add_marker();
        add_instr(enc_b(13'd8, 5'd2, 5'd1, 3'b100));
        add_instr(enc_sw(12'd52, 5'd3, 5'd10));
        add_instr(enc_b(13'd8, 5'd2, 5'd1, 3'b101));
        add_marker();
        add_instr(enc_b(13'd8, 5'd1, 5'd2, 3'b101));
        add_instr(enc_sw(12'd56, 5'd4, 5'd10));
        add_instr(enc_b(13'd8, 5'd2, 5'd1, 3'b110));
        add_marker();
        add_instr(enc_b(13'd8, 5'd1, 5'd2, 3'b110));
        add_instr(enc_sw(12'd60, 5'd5, 5'd10));
        add_instr(enc_b(13'd8, 5'd1, 5'd2, 3'b111));
        add_marker();
        add_instr(enc_b(13'd8, 5'd2, 5'd1, 3'b111));
        add_instr(enc_sw(12'd64, 5'd6, 5'd10));
        // jal at 200 and jalr at 216
        add_instr(enc_jal(21'd8, 5'd17));
        add_marker();
        add_instr(enc_sw(12'd68, 5'd17, 5'd10));
        add_instr(enc_i(12'd228, 5'd0, 3'b000, 5'd18, OPC_OP_IMM));
        add_instr(enc_i(12'd0, 5'd18, 3'b000, 5'd19, OPC_JALR));
        add_marker();
        add_marker();
        add_instr(enc_sw(12'd72, 5'd19, 5'd10));
        add_instr(enc_u(20'habcde, 5'd20, OPC_LUI));
        add_instr(enc_sw(12'd76, 5'd20, 5'd10));
        add_instr(enc_u(20'h00001, 5'd21, OPC_AUIPC));
        add_instr(enc_sw(12'd80, 5'd21, 5'd10));
        // self-jump at 248
        add_instr(enc_jal(21'd0, 5'd0));
    endtask

    task automatic build_stores();
        add_store(32'd512, 32'd5);
        add_store(32'd516, 32'd2);
        add_store(32'd520, 32'd8);
        add_store(32'd524, 32'hffff_fff8);
        add_store(32'd528, 32'hffff_fffd);
        add_store(32'd532, 32'd5);
        add_store(32'd536, 32'h0000_00a0);
        add_store(32'd540, 32'hffff_ffff);
        add_store(32'd544, 32'd1);
        add_store(32'd548, 32'd0);
        add_store(32'd552, 32'h1234_5679);
        add_store(32'd556, 32'd5);
        add_store(32'd560, 32'hffff_fffd);
        add_store(32'd564, 32'd2);
        add_store(32'd568, 32'd8);
        add_store(32'd572, 32'hffff_fff8);
        add_store(32'd576, 32'hffff_fffd);
        add_store(32'd580, 32'd204);
        add_store(32'd584, 32'd220);
        add_store(32'd588, 32'habcd_e000);
        add_store(32'd592, 32'h0000_10f0);
    endtask

    // bus slave with 0 to 3 wait cycles per access
    always @(posedge clk) begin
        rv_pkg::bus_req_t exp_req;
        int               idx;
        if (reset) begin
            bus_rsp <= '0;
            in_cycle = 1'b0;
        end else if (bus_rsp.ack) begin
            bus_rsp.ack <= 1'b0;
        end else if (bus_req.cyc && bus_req.stb) begin
            if (!in_cycle) begin
                in_cycle = 1'b1;
                rng_state = xorshift(rng_state);
                wait_left = int'(rng_state % 4);
                exp_req = '0;
                if (!first_seen) begin
                    first_seen = 1'b1;
                    check_req("bus_req first access", exp_req, bus_req);
                end
                if (expect_fetch) begin
                    expect_fetch = 1'b0;
                    exp_req.addr = fetch_target;
                    check_req("bus_req fetch after jump", exp_req, bus_req);
                    jumps_seen++;
                end
            end
            if (wait_left == 0) begin
                in_cycle = 1'b0;
                if (bus_req.addr >= 4 * MEM_WORDS) begin
                    $display("access outside the memory model at address %h", bus_req.addr);
                    fail_now();
                end
                idx = int'(bus_req.addr >> 2);
                bus_rsp.ack <= 1'b1;
                bus_rsp.rdata <= mem[idx];
                if (bus_req.we) begin
                    if (store_idx >= n_stores) begin
                        $display("write at %h after the last expected store", bus_req.addr);
                        fail_now();
                    end
                    exp_req = '0;
                    exp_req.addr = exp_addr[store_idx];
                    exp_req.we = 1'b1;
                    check_req("bus_req store", exp_req, bus_req);
                    check_word("bus_req.wdata", exp_data[store_idx], bus_req.wdata);
                    mem[idx] = bus_req.wdata;
                    store_idx++;
                end else begin
                    for (int j = 0; j < 3; j++) begin
                        if (bus_req.addr == jump_from[j]) begin
                            expect_fetch = 1'b1;
                            fetch_target = jump_to[j];
                        end
                    end
                end
            end else begin
                wait_left--;
            end
        end
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        bus_rsp <= '0;
        n_prog = 0;
        n_stores = 0;
        store_idx = 0;
        jumps_seen = 0;
        cycles = 0;
        in_cycle = 1'b0;
        first_seen = 1'b0;
        expect_fetch = 1'b0;
        fetch_target = '0;
        rng_state = 32'h5dcc_df05;
        jump_from[0] = 32'd200;
        jump_to[0] = 32'd208;
        jump_from[1] = 32'd216;
        jump_to[1] = 32'd228;
        jump_from[2] = 32'd248;
        jump_to[2] = 32'd248;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'hdead_0000 ^ (i << 2);
        end
        build_program();
        build_stores();
        for (int i = 0; i < n_prog; i++) begin
            mem[i] = prog[i];
        end
        mem[64] = 32'h1234_5678;
        limit = n_prog * 20 + 100;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        // run on until the self-jump has fetched its own address again
        while (store_idx < n_stores || jumps_seen < 3) begin
            @(posedge clk);
            cycles++;
            if (cycles > limit) begin
                $display("timeout after %0d cycles with %0d of %0d stores and %0d of 3 jumps seen",
                         cycles, store_idx, n_stores, jumps_seen);
                fail_now();
            end
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+.
source/rv_pkg.sv
source/rv_alu.sv
source/rv_regfile.sv
source/rv_decoder.sv
source/rv_bus_master.sv
source/rv_control.sv
source/rv_core.sv
testbench/tb_rv_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
